/* design/rv_ctrl_defines.svh */
`ifndef RV_CTRL_DEFINES_SVH
`define RV_CTRL_DEFINES_SVH

// instruction word width for the base integer set
`define RV_XLEN 32

// the opcode always sits in the low bits of the word
`define RV_OPCODE_MSB 6

// destination register
`define RV_RD_MSB 11
`define RV_RD_LSB 7

// first source register
`define RV_RS1_MSB 19
`define RV_RS1_LSB 15

// second source register, bit 20 also tells EBREAK from ECALL
`define RV_RS2_MSB 24
`define RV_RS2_LSB 20

`define RV_FUNCT3_MSB 14 // minor opcode
`define RV_FUNCT3_LSB 12

`define RV_FUNCT7_MSB 31 // bit 30 selects SUB, SRA and SRAI
`define RV_FUNCT7_LSB 25

`define RV_REG_ADDR_W 5 // 32 architectural registers

`endif

/* design/rv_ctrl_pkg.sv */
`include "rv_ctrl_defines.svh"

package rv_ctrl_pkg;

    typedef enum logic [`RV_OPCODE_MSB:0] {
        R_TYPE  = 7'b0110011, // register-register alu
        I_TYPE  = 7'b0010011, // register-immediate alu
        I_LOAD  = 7'b0000011,
        I_JALR  = 7'b1100111,
        I_ENV   = 7'b1110011, // ecall and ebreak
        S_TYPE  = 7'b0100011,
        B_TYPE  = 7'b1100011,
        U_LUI   = 7'b0110111,
        U_AUIPC = 7'b0010111,
        J_TYPE  = 7'b1101111
    } opcode_e;

    typedef enum logic [5:0] {
        OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU,
        OP_XOR, OP_SRL, OP_SRA, OP_OR, OP_AND,
        OP_ADDI, OP_SLLI, OP_SLTI, OP_SLTIU, OP_XORI,
        OP_SRLI, OP_SRAI, OP_ORI, OP_ANDI,
        OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU,
        OP_SB, OP_SH, OP_SW,
        OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
        OP_JAL, OP_JALR, OP_LUI, OP_AUIPC,
        OP_ECALL, OP_EBREAK,
        OP_NA = 6'h3f // illegal or unsupported encoding
    } mnemonic_e;

    // SLTU and the unsigned branches reuse ALU_SLT with alu_signed low
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_e;

    typedef enum logic [2:0] {
        IMM_I,
        IMM_S,
        IMM_B,
        IMM_J,
        IMM_U
    } imm_fmt_e;

    typedef enum logic [2:0] {
        BR_NONE,
        BR_ALWAYS, // jal and jalr
        BR_EQ,
        BR_NE,
        BR_LT,     // taken on the alu less-than flag
        BR_GE
    } branch_e;

    typedef struct packed {
        logic [`RV_REG_ADDR_W-1:0]              rs1;
        logic [`RV_REG_ADDR_W-1:0]              rs2;
        logic [`RV_REG_ADDR_W-1:0]              rd;
        logic [`RV_FUNCT3_MSB-`RV_FUNCT3_LSB:0] funct3;
        logic [`RV_FUNCT7_MSB-`RV_FUNCT7_LSB:0] funct7;
    } instr_fields_t;

    typedef struct packed {
        logic     result_src; // 1 selects load data for write-back
        logic     mem_write;
        logic     reg_write;
        logic     alu_src_a;  // 1 selects the pc as operand a
        logic     alu_src_b;  // 1 selects the immediate as operand b
        alu_op_e  alu_op;
        logic     alu_signed; // signed compare or sign-extended load
        imm_fmt_e imm_fmt;
        branch_e  branch;
    } ctrl_t;

endpackage

/* design/rv_instr_decode.sv */
`timescale 1ns/1ps

`include "rv_ctrl_defines.svh"

module rv_instr_decode (
    input  logic [`RV_XLEN-1:0]        instr,
    output rv_ctrl_pkg::instr_fields_t fields,
    output rv_ctrl_pkg::mnemonic_e     mnemonic
);

    rv_ctrl_pkg::opcode_e opcode;
    logic                 alt_bit; // funct7 bit 5 picks the alternate alu function

    // an unknown opcode still casts, the case default turns it into OP_NA
    assign opcode = rv_ctrl_pkg::opcode_e'(instr[`RV_OPCODE_MSB:0]);

    assign fields.rs1    = instr[`RV_RS1_MSB:`RV_RS1_LSB];
    assign fields.rs2    = instr[`RV_RS2_MSB:`RV_RS2_LSB];
    assign fields.rd     = instr[`RV_RD_MSB:`RV_RD_LSB];
    assign fields.funct3 = instr[`RV_FUNCT3_MSB:`RV_FUNCT3_LSB];
    assign fields.funct7 = instr[`RV_FUNCT7_MSB:`RV_FUNCT7_LSB];

    assign alt_bit = fields.funct7[5];

    always_comb begin
        case (opcode)
            rv_ctrl_pkg::R_TYPE: begin
                case (fields.funct3)
                    3'h0: mnemonic = alt_bit ? rv_ctrl_pkg::OP_SUB : rv_ctrl_pkg::OP_ADD;
                    3'h1: mnemonic = rv_ctrl_pkg::OP_SLL;
                    3'h2: mnemonic = rv_ctrl_pkg::OP_SLT;
                    3'h3: mnemonic = rv_ctrl_pkg::OP_SLTU;
                    3'h4: mnemonic = rv_ctrl_pkg::OP_XOR;
                    3'h5: mnemonic = alt_bit ? rv_ctrl_pkg::OP_SRA : rv_ctrl_pkg::OP_SRL;
                    3'h6: mnemonic = rv_ctrl_pkg::OP_OR;
                    default: mnemonic = rv_ctrl_pkg::OP_AND;
                endcase
            end
            rv_ctrl_pkg::I_TYPE: begin
                // bit 30 only matters for the shifts, elsewhere it is immediate data
                case (fields.funct3)
                    3'h0: mnemonic = rv_ctrl_pkg::OP_ADDI;
                    3'h1: mnemonic = rv_ctrl_pkg::OP_SLLI;
                    3'h2: mnemonic = rv_ctrl_pkg::OP_SLTI;
                    3'h3: mnemonic = rv_ctrl_pkg::OP_SLTIU;
                    3'h4: mnemonic = rv_ctrl_pkg::OP_XORI;
                    3'h5: mnemonic = alt_bit ? rv_ctrl_pkg::OP_SRAI : rv_ctrl_pkg::OP_SRLI;
                    3'h6: mnemonic = rv_ctrl_pkg::OP_ORI;
                    default: mnemonic = rv_ctrl_pkg::OP_ANDI;
                endcase
            end
            rv_ctrl_pkg::I_LOAD: begin
                case (fields.funct3)
                    3'h0: mnemonic = rv_ctrl_pkg::OP_LB;
                    3'h1: mnemonic = rv_ctrl_pkg::OP_LH;
                    3'h2: mnemonic = rv_ctrl_pkg::OP_LW;
                    3'h4: mnemonic = rv_ctrl_pkg::OP_LBU;
                    3'h5: mnemonic = rv_ctrl_pkg::OP_LHU;
                    default: mnemonic = rv_ctrl_pkg::OP_NA; // no 64-bit loads here
                endcase
            end
            rv_ctrl_pkg::S_TYPE: begin
                case (fields.funct3)
                    3'h0: mnemonic = rv_ctrl_pkg::OP_SB;
                    3'h1: mnemonic = rv_ctrl_pkg::OP_SH;
                    3'h2: mnemonic = rv_ctrl_pkg::OP_SW;
                    default: mnemonic = rv_ctrl_pkg::OP_NA;
                endcase
            end
            rv_ctrl_pkg::B_TYPE: begin
                case (fields.funct3)
                    3'h0: mnemonic = rv_ctrl_pkg::OP_BEQ;
                    3'h1: mnemonic = rv_ctrl_pkg::OP_BNE;
                    3'h4: mnemonic = rv_ctrl_pkg::OP_BLT;
                    3'h5: mnemonic = rv_ctrl_pkg::OP_BGE;
                    3'h6: mnemonic = rv_ctrl_pkg::OP_BLTU;
                    3'h7: mnemonic = rv_ctrl_pkg::OP_BGEU;
                    default: mnemonic = rv_ctrl_pkg::OP_NA; // 2 and 3 are reserved
                endcase
            end
            rv_ctrl_pkg::I_ENV: begin
                // the low immediate bit lands on bit 20
                mnemonic = instr[`RV_RS2_LSB] ? rv_ctrl_pkg::OP_EBREAK : rv_ctrl_pkg::OP_ECALL;
            end
            rv_ctrl_pkg::I_JALR:  mnemonic = rv_ctrl_pkg::OP_JALR;
            rv_ctrl_pkg::J_TYPE:  mnemonic = rv_ctrl_pkg::OP_JAL;
            rv_ctrl_pkg::U_LUI:   mnemonic = rv_ctrl_pkg::OP_LUI;
            rv_ctrl_pkg::U_AUIPC: mnemonic = rv_ctrl_pkg::OP_AUIPC;
            default:              mnemonic = rv_ctrl_pkg::OP_NA;
        endcase
    end

endmodule

/* design/rv_ctrl_table.sv */
`timescale 1ns/1ps

module rv_ctrl_table (
    input  rv_ctrl_pkg::mnemonic_e mnemonic,
    output rv_ctrl_pkg::ctrl_t     ctrl
);

    // no write, no jump, immediate ignored
    localparam rv_ctrl_pkg::ctrl_t CTRL_NOP = '0;

    localparam rv_ctrl_pkg::ctrl_t CTRL_REG = '{
        result_src: 1'b0, mem_write: 1'b0, reg_write: 1'b1, alu_src_a: 1'b0, alu_src_b: 1'b0,
        alu_op: rv_ctrl_pkg::ALU_ADD, alu_signed: 1'b0,
        imm_fmt: rv_ctrl_pkg::IMM_I, branch: rv_ctrl_pkg::BR_NONE
    };

    localparam rv_ctrl_pkg::ctrl_t CTRL_IMM = '{
        result_src: 1'b0, mem_write: 1'b0, reg_write: 1'b1, alu_src_a: 1'b0, alu_src_b: 1'b1,
        alu_op: rv_ctrl_pkg::ALU_ADD, alu_signed: 1'b0,
        imm_fmt: rv_ctrl_pkg::IMM_I, branch: rv_ctrl_pkg::BR_NONE
    };

    // the alu forms the address as rs1 plus the I-immediate
    localparam rv_ctrl_pkg::ctrl_t CTRL_LOAD = '{
        result_src: 1'b1, mem_write: 1'b0, reg_write: 1'b1, alu_src_a: 1'b0, alu_src_b: 1'b1,
        alu_op: rv_ctrl_pkg::ALU_ADD, alu_signed: 1'b0,
        imm_fmt: rv_ctrl_pkg::IMM_I, branch: rv_ctrl_pkg::BR_NONE
    };

    localparam rv_ctrl_pkg::ctrl_t CTRL_STORE = '{
        result_src: 1'b0, mem_write: 1'b1, reg_write: 1'b0, alu_src_a: 1'b0, alu_src_b: 1'b1,
        alu_op: rv_ctrl_pkg::ALU_ADD, alu_signed: 1'b0,
        imm_fmt: rv_ctrl_pkg::IMM_S, branch: rv_ctrl_pkg::BR_NONE
    };

    // branches compare two registers, the target adder lives outside the alu
    localparam rv_ctrl_pkg::ctrl_t CTRL_BRANCH = '{
        result_src: 1'b0, mem_write: 1'b0, reg_write: 1'b0, alu_src_a: 1'b0, alu_src_b: 1'b0,
        alu_op: rv_ctrl_pkg::ALU_SUB, alu_signed: 1'b0,
        imm_fmt: rv_ctrl_pkg::IMM_B, branch: rv_ctrl_pkg::BR_NONE
    };

    localparam rv_ctrl_pkg::ctrl_t CTRL_UPPER = '{
        result_src: 1'b0, mem_write: 1'b0, reg_write: 1'b1, alu_src_a: 1'b0, alu_src_b: 1'b1,
        alu_op: rv_ctrl_pkg::ALU_ADD, alu_signed: 1'b0,
        imm_fmt: rv_ctrl_pkg::IMM_U, branch: rv_ctrl_pkg::BR_NONE
    };

    function automatic rv_ctrl_pkg::ctrl_t alu_row(
        input rv_ctrl_pkg::ctrl_t   base,
        input rv_ctrl_pkg::alu_op_e op,
        input logic                 sgn
    );
        rv_ctrl_pkg::ctrl_t row;
        row            = base;
        row.alu_op     = op;
        row.alu_signed = sgn;
        return row;
    endfunction

    function automatic rv_ctrl_pkg::ctrl_t br_row(
        input rv_ctrl_pkg::branch_e br,
        input rv_ctrl_pkg::alu_op_e op,
        input logic                 sgn
    );
        rv_ctrl_pkg::ctrl_t row;
        row        = alu_row(CTRL_BRANCH, op, sgn);
        row.branch = br;
        return row;
    endfunction

    always_comb begin
        case (mnemonic)
            rv_ctrl_pkg::OP_ADD:  ctrl = alu_row(CTRL_REG, rv_ctrl_pkg::ALU_ADD, 1'b0);
            rv_ctrl_pkg::OP_SUB:  ctrl = alu_row(CTRL_REG, rv_ctrl_pkg::ALU_SUB, 1'b0);
            rv_ctrl_pkg::OP_SLL:  ctrl = alu_row(CTRL_REG, rv_ctrl_pkg::ALU_SLL, 1'b0);
            rv_ctrl_pkg::OP_SLT:  ctrl = alu_row(CTRL_REG, rv_ctrl_pkg::ALU_SLT, 1'b1);
            rv_ctrl_pkg::OP_SLTU: ctrl = alu_row(CTRL_REG, rv_ctrl_pkg::ALU_SLT, 1'b0);
            rv_ctrl_pkg::OP_XOR:  ctrl = alu_row(CTRL_REG, rv_ctrl_pkg::ALU_XOR, 1'b0);
            rv_ctrl_pkg::OP_SRL:  ctrl = alu_row(CTRL_REG, rv_ctrl_pkg::ALU_SRL, 1'b0);
            rv_ctrl_pkg::OP_SRA:  ctrl = alu_row(CTRL_REG, rv_ctrl_pkg::ALU_SRA, 1'b0);
            rv_ctrl_pkg::OP_OR:   ctrl = alu_row(CTRL_REG, rv_ctrl_pkg::ALU_OR, 1'b0);
            rv_ctrl_pkg::OP_AND:  ctrl = alu_row(CTRL_REG, rv_ctrl_pkg::ALU_AND, 1'b0);

            rv_ctrl_pkg::OP_ADDI:  ctrl = alu_row(CTRL_IMM, rv_ctrl_pkg::ALU_ADD, 1'b0);
            rv_ctrl_pkg::OP_SLLI:  ctrl = alu_row(CTRL_IMM, rv_ctrl_pkg::ALU_SLL, 1'b0);
            rv_ctrl_pkg::OP_SLTI:  ctrl = alu_row(CTRL_IMM, rv_ctrl_pkg::ALU_SLT, 1'b1);
            rv_ctrl_pkg::OP_SLTIU: ctrl = alu_row(CTRL_IMM, rv_ctrl_pkg::ALU_SLT, 1'b0);
            rv_ctrl_pkg::OP_XORI:  ctrl = alu_row(CTRL_IMM, rv_ctrl_pkg::ALU_XOR, 1'b0);
            rv_ctrl_pkg::OP_SRLI:  ctrl = alu_row(CTRL_IMM, rv_ctrl_pkg::ALU_SRL, 1'b0);
            rv_ctrl_pkg::OP_SRAI:  ctrl = alu_row(CTRL_IMM, rv_ctrl_pkg::ALU_SRA, 1'b0);
            rv_ctrl_pkg::OP_ORI:   ctrl = alu_row(CTRL_IMM, rv_ctrl_pkg::ALU_OR, 1'b0);
            rv_ctrl_pkg::OP_ANDI:  ctrl = alu_row(CTRL_IMM, rv_ctrl_pkg::ALU_AND, 1'b0);

            // alu_signed on a load asks for sign extension of the data
            rv_ctrl_pkg::OP_LB:  ctrl = alu_row(CTRL_LOAD, rv_ctrl_pkg::ALU_ADD, 1'b1);
            rv_ctrl_pkg::OP_LH:  ctrl = alu_row(CTRL_LOAD, rv_ctrl_pkg::ALU_ADD, 1'b1);
            rv_ctrl_pkg::OP_LW:  ctrl = alu_row(CTRL_LOAD, rv_ctrl_pkg::ALU_ADD, 1'b1);
            rv_ctrl_pkg::OP_LBU: ctrl = CTRL_LOAD;
            rv_ctrl_pkg::OP_LHU: ctrl = CTRL_LOAD;

            rv_ctrl_pkg::OP_SB, rv_ctrl_pkg::OP_SH, rv_ctrl_pkg::OP_SW: ctrl = CTRL_STORE;

            rv_ctrl_pkg::OP_BEQ:
                ctrl = br_row(rv_ctrl_pkg::BR_EQ, rv_ctrl_pkg::ALU_SUB, 1'b0);
            rv_ctrl_pkg::OP_BNE:
                ctrl = br_row(rv_ctrl_pkg::BR_NE, rv_ctrl_pkg::ALU_SUB, 1'b0);
            rv_ctrl_pkg::OP_BLT:
                ctrl = br_row(rv_ctrl_pkg::BR_LT, rv_ctrl_pkg::ALU_SLT, 1'b1);
            rv_ctrl_pkg::OP_BGE:
                ctrl = br_row(rv_ctrl_pkg::BR_GE, rv_ctrl_pkg::ALU_SLT, 1'b1);
            rv_ctrl_pkg::OP_BLTU:
                ctrl = br_row(rv_ctrl_pkg::BR_LT, rv_ctrl_pkg::ALU_SLT, 1'b0);
            rv_ctrl_pkg::OP_BGEU:
                ctrl = br_row(rv_ctrl_pkg::BR_GE, rv_ctrl_pkg::ALU_SLT, 1'b0);

            // the link register write stays off for both jumps
            rv_ctrl_pkg::OP_JAL: begin
                ctrl         = CTRL_NOP;
                ctrl.imm_fmt = rv_ctrl_pkg::IMM_J;
                ctrl.branch  = rv_ctrl_pkg::BR_ALWAYS;
            end
            rv_ctrl_pkg::OP_JALR: begin
                ctrl        = CTRL_NOP;
                ctrl.branch = rv_ctrl_pkg::BR_ALWAYS; // target from rs1 plus the I-immediate
            end

            rv_ctrl_pkg::OP_LUI: ctrl = CTRL_UPPER;
            rv_ctrl_pkg::OP_AUIPC: begin
                ctrl           = CTRL_UPPER;
                ctrl.alu_src_a = 1'b1; // pc plus the upper immediate
            end

            default: ctrl = CTRL_NOP; // ecall, ebreak and illegal words
        endcase
    end

endmodule

/* design/rv_ctrl_stage.sv */
`timescale 1ns/1ps

module rv_ctrl_stage (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       instr_valid,
    input  rv_ctrl_pkg::instr_fields_t fields,
    input  rv_ctrl_pkg::mnemonic_e     mnemonic,
    input  rv_ctrl_pkg::ctrl_t         ctrl,
    input  logic                       alu_zero,
    input  logic                       alu_slt,
    output logic                       out_valid,
    output rv_ctrl_pkg::instr_fields_t out_fields,
    output rv_ctrl_pkg::mnemonic_e     out_mnemonic,
    output rv_ctrl_pkg::ctrl_t         out_ctrl,
    output logic                       pc_src
);

    logic taken; // branch condition before the valid qualifier

    // a bubble loads all-zero controls so no write leaks out of an idle slot
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
            out_ctrl  <= '0;
        end else begin
            out_valid <= instr_valid;
            out_ctrl  <= instr_valid ? ctrl : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (instr_valid) begin
            out_fields   <= fields;
            out_mnemonic <= mnemonic;
        end
    end

    // the flags belong to the instruction now held in this stage
    always_comb begin
        case (out_ctrl.branch)
            rv_ctrl_pkg::BR_ALWAYS: taken = 1'b1;
            rv_ctrl_pkg::BR_EQ:     taken = alu_zero;
            rv_ctrl_pkg::BR_NE:     taken = !alu_zero;
            rv_ctrl_pkg::BR_LT:     taken = alu_slt;
            rv_ctrl_pkg::BR_GE:     taken = !alu_slt;
            default:                taken = 1'b0;
        endcase
    end

    assign pc_src = out_valid & taken;

endmodule

/* design/rv_ctrl_top.sv */
`timescale 1ns/1ps

`include "rv_ctrl_defines.svh"

module rv_ctrl_top (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       instr_valid,
    input  logic [`RV_XLEN-1:0]        instr,
    input  logic                       alu_zero,
    input  logic                       alu_slt,
    output logic                       out_valid,
    output rv_ctrl_pkg::instr_fields_t out_fields,
    output rv_ctrl_pkg::mnemonic_e     out_mnemonic,
    output rv_ctrl_pkg::ctrl_t         out_ctrl,
    output logic                       pc_src
);

    rv_ctrl_pkg::instr_fields_t dec_fields;
    rv_ctrl_pkg::mnemonic_e     dec_mnemonic;
    rv_ctrl_pkg::ctrl_t         dec_ctrl;

    rv_instr_decode u_decode (
        .instr    (instr),
        .fields   (dec_fields),
        .mnemonic (dec_mnemonic)
    );

    rv_ctrl_table u_table (
        .mnemonic (dec_mnemonic),
        .ctrl     (dec_ctrl)
    );

    rv_ctrl_stage u_stage (
        .clk          (clk),
        .arst_n       (arst_n),
        .instr_valid  (instr_valid),
        .fields       (dec_fields),
        .mnemonic     (dec_mnemonic),
        .ctrl         (dec_ctrl),
        .alu_zero     (alu_zero),
        .alu_slt      (alu_slt),
        .out_valid    (out_valid),
        .out_fields   (out_fields),
        .out_mnemonic (out_mnemonic),
        .out_ctrl     (out_ctrl),
        .pc_src       (pc_src)
    );

endmodule

/* tb/tb_rv_ctrl.sv */
`timescale 1ns/1ps

`include "rv_ctrl_defines.svh"

module tb_rv_ctrl;

    localparam int RESET_CYCLES = 5;
    localparam int SWEEP_WORDS  = 10 * 8 * 2; // every opcode, funct3 and bit 30
    localparam int RANDOM_WORDS = 400;
    localparam int STIM_CYCLES  = RESET_CYCLES + 1 + SWEEP_WORDS + RANDOM_WORDS + 2;
    localparam int MAX_CYCLES   = 2 * STIM_CYCLES + 20;

    typedef struct packed {
        logic                       valid;
        rv_ctrl_pkg::instr_fields_t fields;
        rv_ctrl_pkg::mnemonic_e     mnemonic;
        rv_ctrl_pkg::ctrl_t         ctrl;
    } expect_t;

    logic                       clk;
    logic                       arst_n;
    logic                       instr_valid;
    logic [`RV_XLEN-1:0]        instr;
    logic                       alu_zero;
    logic                       alu_slt;
    logic                       out_valid;
    rv_ctrl_pkg::instr_fields_t out_fields;
    rv_ctrl_pkg::mnemonic_e     out_mnemonic;
    rv_ctrl_pkg::ctrl_t         out_ctrl;
    logic                       pc_src;

    integer  seed;
    int      cycle_cnt = 0;
    expect_t pending_q[$]; // holds the word that sits in the stage register

    rv_ctrl_top dut0 (.*);

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("timeout: the test did not end within %0d cycles", MAX_CYCLES);
            $display("Simulation failed");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    function automatic logic [31:0] next_rand();
        return $random(seed);
    endfunction

    function automatic logic [6:0] opcode_at(input int idx);
        case (idx)
            0: return rv_ctrl_pkg::R_TYPE;
            1: return rv_ctrl_pkg::I_TYPE;
            2: return rv_ctrl_pkg::I_LOAD;
            3: return rv_ctrl_pkg::I_JALR;
            4: return rv_ctrl_pkg::I_ENV;
            5: return rv_ctrl_pkg::S_TYPE;
            6: return rv_ctrl_pkg::B_TYPE;
            7: return rv_ctrl_pkg::U_LUI;
            8: return rv_ctrl_pkg::U_AUIPC;
            default: return rv_ctrl_pkg::J_TYPE;
        endcase
    endfunction

    // random registers and immediates around a chosen opcode and funct3
    function automatic logic [31:0] build_word(input int idx, input logic [2:0] f3, input logic alt);
        logic [31:0] w;
        w        = next_rand();
        w[6:0]   = opcode_at(idx);
        w[14:12] = f3;
        w[30]    = alt;
        w[20]    = alt; // lets the sweep reach both ECALL and EBREAK
        return w;
    endfunction

    function automatic rv_ctrl_pkg::mnemonic_e expect_mnemonic(input logic [31:0] w);
        if (w[6:0] == 7'b1110011)
            return w[20] ? rv_ctrl_pkg::OP_EBREAK : rv_ctrl_pkg::OP_ECALL;
        casez ({w[6:0], w[14:12], w[30]}) // opcode, funct3, funct7 bit 5
            11'b0110011_000_0: return rv_ctrl_pkg::OP_ADD;
            11'b0110011_000_1: return rv_ctrl_pkg::OP_SUB;
            11'b0110011_001_?: return rv_ctrl_pkg::OP_SLL;
            11'b0110011_010_?: return rv_ctrl_pkg::OP_SLT;
            11'b0110011_011_?: return rv_ctrl_pkg::OP_SLTU;
            11'b0110011_100_?: return rv_ctrl_pkg::OP_XOR;
            11'b0110011_101_0: return rv_ctrl_pkg::OP_SRL;
            11'b0110011_101_1: return rv_ctrl_pkg::OP_SRA;
            11'b0110011_110_?: return rv_ctrl_pkg::OP_OR;
            11'b0110011_111_?: return rv_ctrl_pkg::OP_AND;
            11'b0010011_000_?: return rv_ctrl_pkg::OP_ADDI;
            11'b0010011_001_?: return rv_ctrl_pkg::OP_SLLI;
            11'b0010011_010_?: return rv_ctrl_pkg::OP_SLTI;
            11'b0010011_011_?: return rv_ctrl_pkg::OP_SLTIU;
            11'b0010011_100_?: return rv_ctrl_pkg::OP_XORI;
            11'b0010011_101_0: return rv_ctrl_pkg::OP_SRLI;
            11'b0010011_101_1: return rv_ctrl_pkg::OP_SRAI;
            11'b0010011_110_?: return rv_ctrl_pkg::OP_ORI;
            11'b0010011_111_?: return rv_ctrl_pkg::OP_ANDI;
            11'b0000011_000_?: return rv_ctrl_pkg::OP_LB;
            11'b0000011_001_?: return rv_ctrl_pkg::OP_LH;
            11'b0000011_010_?: return rv_ctrl_pkg::OP_LW;
            11'b0000011_100_?: return rv_ctrl_pkg::OP_LBU;
            11'b0000011_101_?: return rv_ctrl_pkg::OP_LHU;
            11'b0100011_000_?: return rv_ctrl_pkg::OP_SB;
            11'b0100011_001_?: return rv_ctrl_pkg::OP_SH;
            11'b0100011_010_?: return rv_ctrl_pkg::OP_SW;
            11'b1100011_000_?: return rv_ctrl_pkg::OP_BEQ;
            11'b1100011_001_?: return rv_ctrl_pkg::OP_BNE;
            11'b1100011_100_?: return rv_ctrl_pkg::OP_BLT;
            11'b1100011_101_?: return rv_ctrl_pkg::OP_BGE;
            11'b1100011_110_?: return rv_ctrl_pkg::OP_BLTU;
            11'b1100011_111_?: return rv_ctrl_pkg::OP_BGEU;
            11'b1100111_???_?: return rv_ctrl_pkg::OP_JALR;
            11'b1101111_???_?: return rv_ctrl_pkg::OP_JAL;
            11'b0110111_???_?: return rv_ctrl_pkg::OP_LUI;
            11'b0010111_???_?: return rv_ctrl_pkg::OP_AUIPC;
            default: return rv_ctrl_pkg::OP_NA;
        endcase
    endfunction

    function automatic rv_ctrl_pkg::alu_op_e alu_function(input rv_ctrl_pkg::mnemonic_e m);
        case (m)
            rv_ctrl_pkg::OP_SUB: return rv_ctrl_pkg::ALU_SUB;
            rv_ctrl_pkg::OP_SLL, rv_ctrl_pkg::OP_SLLI: return rv_ctrl_pkg::ALU_SLL;
            rv_ctrl_pkg::OP_SLT, rv_ctrl_pkg::OP_SLTU,
            rv_ctrl_pkg::OP_SLTI, rv_ctrl_pkg::OP_SLTIU: return rv_ctrl_pkg::ALU_SLT;
            rv_ctrl_pkg::OP_XOR, rv_ctrl_pkg::OP_XORI: return rv_ctrl_pkg::ALU_XOR;
            rv_ctrl_pkg::OP_SRL, rv_ctrl_pkg::OP_SRLI: return rv_ctrl_pkg::ALU_SRL;
            rv_ctrl_pkg::OP_SRA, rv_ctrl_pkg::OP_SRAI: return rv_ctrl_pkg::ALU_SRA;
            rv_ctrl_pkg::OP_OR, rv_ctrl_pkg::OP_ORI: return rv_ctrl_pkg::ALU_OR;
            rv_ctrl_pkg::OP_AND, rv_ctrl_pkg::OP_ANDI: return rv_ctrl_pkg::ALU_AND;
            default: return rv_ctrl_pkg::ALU_ADD;
        endcase
    endfunction

    // instruction groups follow the opcode, details follow funct3
    function automatic rv_ctrl_pkg::ctrl_t expect_ctrl(input logic [31:0] w,
                                                       input rv_ctrl_pkg::mnemonic_e m);
        rv_ctrl_pkg::ctrl_t c;
        c = '0;
        if (m == rv_ctrl_pkg::OP_NA)
            return c;
        case (w[6:0])
            rv_ctrl_pkg::R_TYPE, rv_ctrl_pkg::I_TYPE: begin
                c.reg_write  = 1'b1;
                c.alu_src_b  = (w[6:0] == rv_ctrl_pkg::I_TYPE);
                c.alu_op     = alu_function(m);
                c.alu_signed = (m == rv_ctrl_pkg::OP_SLT) || (m == rv_ctrl_pkg::OP_SLTI);
            end
            rv_ctrl_pkg::I_LOAD: begin
                c.result_src = 1'b1;
                c.reg_write  = 1'b1;
                c.alu_src_b  = 1'b1;
                c.alu_signed = !w[14]; // LB, LH and LW sign-extend
            end
            rv_ctrl_pkg::S_TYPE: begin
                c.mem_write = 1'b1;
                c.alu_src_b = 1'b1;
                c.imm_fmt   = rv_ctrl_pkg::IMM_S;
            end
            rv_ctrl_pkg::B_TYPE: begin
                c.imm_fmt    = rv_ctrl_pkg::IMM_B;
                c.alu_op     = w[14] ? rv_ctrl_pkg::ALU_SLT : rv_ctrl_pkg::ALU_SUB;
                c.alu_signed = w[14] && !w[13];
                if (w[14])
                    c.branch = w[12] ? rv_ctrl_pkg::BR_GE : rv_ctrl_pkg::BR_LT;
                else
                    c.branch = w[12] ? rv_ctrl_pkg::BR_NE : rv_ctrl_pkg::BR_EQ;
            end
            rv_ctrl_pkg::J_TYPE: begin
                c.imm_fmt = rv_ctrl_pkg::IMM_J;
                c.branch  = rv_ctrl_pkg::BR_ALWAYS;
            end
            rv_ctrl_pkg::I_JALR: c.branch = rv_ctrl_pkg::BR_ALWAYS;
            rv_ctrl_pkg::U_LUI, rv_ctrl_pkg::U_AUIPC: begin
                c.reg_write = 1'b1;
                c.alu_src_b = 1'b1;
                c.imm_fmt   = rv_ctrl_pkg::IMM_U;
                c.alu_src_a = (w[6:0] == rv_ctrl_pkg::U_AUIPC);
            end
            default: c = '0; // environment calls
        endcase
        return c;
    endfunction

    function automatic logic branch_taken(input rv_ctrl_pkg::mnemonic_e m,
                                          input logic zero, input logic slt);
        case (m)
            rv_ctrl_pkg::OP_BEQ: return zero;
            rv_ctrl_pkg::OP_BNE: return !zero;
            rv_ctrl_pkg::OP_BLT, rv_ctrl_pkg::OP_BLTU: return slt;
            rv_ctrl_pkg::OP_BGE, rv_ctrl_pkg::OP_BGEU: return !slt;
            rv_ctrl_pkg::OP_JAL, rv_ctrl_pkg::OP_JALR: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("mismatch at %0t: %s expected 0x%0h, got 0x%0h", $time, name, expected, actual);
        $display("Simulation failed");
        $fatal(1, "stopped at the first error");
    endtask

    // the flags still hold the values driven along with the word under check
    task automatic check_outputs(input expect_t e);
        logic taken;
        taken = e.valid && branch_taken(e.mnemonic, alu_zero, alu_slt);
        assert (out_valid === e.valid)
            else report_mismatch("out_valid", 32'(e.valid), 32'(out_valid));
        assert (out_ctrl === e.ctrl)
            else report_mismatch("out_ctrl", 32'(e.ctrl), 32'(out_ctrl));
        assert (pc_src === taken)
            else report_mismatch("pc_src", 32'(taken), 32'(pc_src));
        if (e.valid) begin
            assert (out_fields === e.fields)
                else report_mismatch("out_fields", 32'(e.fields), 32'(out_fields));
            assert (out_mnemonic === e.mnemonic)
                else report_mismatch("out_mnemonic", 32'(e.mnemonic), 32'(out_mnemonic));
        end
    endtask

    task automatic apply_word(input logic valid, input logic [31:0] w);
        logic [31:0] r;
        expect_t     e;
        r           = next_rand();
        instr_valid = valid;
        instr       = w;
        alu_zero    = r[0];
        alu_slt     = r[1];
        e           = '0;
        if (valid) begin
            e.valid    = 1'b1;
            e.fields   = '{rs1: w[19:15], rs2: w[24:20], rd: w[11:7],
                           funct3: w[14:12], funct7: w[31:25]};
            e.mnemonic = expect_mnemonic(w);
            e.ctrl     = expect_ctrl(w, e.mnemonic);
        end
        pending_q.push_back(e);
    endtask

    task automatic next_cycle(input logic valid, input logic [31:0] w);
        expect_t e;
        @(negedge clk);
        e = '0;
        if (pending_q.size() > 0)
            e = pending_q.pop_front();
        check_outputs(e);
        apply_word(valid, w);
    endtask

    initial begin
        int          op;
        int          f3;
        int          alt;
        logic [31:0] r;
        logic [31:0] w;
        expect_t     idle;
        seed        = 32'h76b1_57c5;
        clk         = 1'b0;
        arst_n      = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        alu_zero    = 1'b0;
        alu_slt     = 1'b0;
        idle        = '0;
        // valid words and live flags during reset must not reach the outputs
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            check_outputs(idle);
            r           = next_rand();
            instr_valid = 1'b1;
            instr       = next_rand();
            alu_zero    = r[0];
            alu_slt     = r[1];
        end
        arst_n = 1'b1;
        apply_word(1'b0, '0);
        for (op = 0; op < 10; op++) begin
            for (f3 = 0; f3 < 8; f3++) begin
                for (alt = 0; alt < 2; alt++)
                    next_cycle(1'b1, build_word(op, 3'(f3), 1'(alt)));
            end
        end
        repeat (RANDOM_WORDS) begin
            r = next_rand();
            if (r[31:28] < 4'd10)
                w = build_word(int'(r[31:28]), r[2:0], r[3]);
            else
                w = next_rand(); // raw word, mostly illegal encodings
            next_cycle(r[5:4] != 2'b00, w); // about a quarter of the slots are bubbles
        end
        repeat (2) next_cycle(1'b0, '0);
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

/* sim.f */
+incdir+design
design/rv_ctrl_pkg.sv
design/rv_instr_decode.sv
design/rv_ctrl_table.sv
design/rv_ctrl_stage.sv
design/rv_ctrl_top.sv
tb/tb_rv_ctrl.sv

/* run.sh */
#!/bin/sh
# build and run the decoder testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module tb_rv_ctrl

# the run passes only if the pass line shows up in the simulator output
./obj_dir/Vtb_rv_ctrl | tee /dev/stderr | grep "Simulation completed successfully" > /dev/null
echo "run.sh: simulation passed"
